/* waveGenTop.f */
source/waveGenPkg.sv
source/chanCfgIf.sv
source/tickDivider.sv
source/stepCalc.sv
source/waveChannel.sv
source/dacSpiWriter.sv
source/waveGenTop.sv
dv/waveGenTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= waveGenTb
FILELIST  ?= waveGenTop.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

# A $fatal in the testbench gives a nonzero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* dv/waveGenTb.sv */
`timescale 1ns/100ps
`default_nettype none

module waveGenTb import waveGenPkg::*; ;

    typedef struct {
        waveMode_t modeA;
        waveMode_t modeB;
        int freqA;
        int freqB;
        int amplA;
        int amplB;
        int offA;
        int offB;
        int count;  // Pairs checked after the two in flight
    } stimRow_t;

    localparam int NumRows = 5;

    logic clk;
    logic rst;
    waveMode_t modeA;
    waveMode_t modeB;
    freqHz_t freqA;
    freqHz_t freqB;
    ampl_t amplA;
    ampl_t amplB;
    ampl_t offsetA;
    ampl_t offsetB;
    logic dacCs;
    logic dacSclk;
    logic dacSdi;
    logic dacLdac;

    stimRow_t rows[NumRows];
    int seed;
    logic tableReady = 1'b0;

    // SPI decoder state
    logic sclkPrev;
    logic csPrev;
    logic ldacPrev;
    logic [FrameBits-1:0] shiftIn;
    int bitsIn;
    logic [FrameBits-1:0] frameQ[$];
    logic [FrameBits-1:0] pairA;
    logic [FrameBits-1:0] pairB;
    int pairCount = 0;

    waveGenTop dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Samples per period, 0 Hz taken as 1 Hz
    function automatic int periodOf(input int freq);
        int p;
        p = SampleHz / ((freq == 0) ? 1 : freq);
        return (p < 1) ? 1 : p;
    endfunction

    // Expected DAC code for sample n of one channel
    function automatic int expCode(input waveMode_t mode, input int freq, input int ampl,
                                   input int off, input int n);
        int sc;
        int half;
        int w;
        int c;
        sc   = periodOf(freq);
        half = sc / 2;
        case (mode)
            modeSaw:    w = -ampl + (2 * ampl / sc) * n;
            modeTri: begin
                if (n < half) begin
                    w = -ampl + (2 * ampl / ((half < 1) ? 1 : half)) * n;
                end else begin
                    w = ampl - (2 * ampl / ((half < 1) ? 1 : half)) * (n - half);
                end
            end
            modeSquare: w = (n < half) ? ampl : -ampl;
            default:    w = 0;
        endcase
        c = DacMid + off + w;
        if (c < 0) c = 0;  // Clamp to the 12-bit range
        else if (c > (1 << DacBits) - 1) c = (1 << DacBits) - 1;
        return c;
    endfunction

    task automatic fillTable();
        int rndA;
        int rndB;
        rndA = {$random(seed)} % 1048;  // Amplitudes 1000..2047
        rndB = {$random(seed)} % 1048;
        rows[0] = '{modeDc, modeDc, 0, 0, 0, 0, 300, 2500, 3};  // B clamps high
        rows[1] = '{modeSaw, modeTri, 1000, 500, 1000, 800, 0, 100, 105};
        rows[2] = '{modeSquare, modeSquare, 2000, 5000, 1500, 700, -200, 50, 30};
        rows[3] = '{modeSquare, modeSaw, 2000, 2500, 1500, 400, -200, -100, 25};  // Only B
        rows[4] = '{modeTri, modeSaw, 1000, 1250, 1000 + rndA, 1000 + rndB, -1200, -1300, 45};
    endtask

    task automatic waitPair();
        int target;
        target = pairCount + 1;
        wait (pairCount == target);
    endtask

    // Frames are collected between CS edges, pairs on the LDAC rising edge
    always @(negedge clk) begin
        if (rst) begin
            bitsIn = 0;
            frameQ.delete();
        end else begin
            if (dacSclk && !sclkPrev && !dacCs) begin
                shiftIn = {shiftIn[FrameBits-2:0], dacSdi};
                bitsIn++;
            end
            if (dacCs && !csPrev) begin
                checkEq("frame length", bitsIn, FrameBits);
                frameQ.push_back(shiftIn);
                bitsIn = 0;
            end
            if (dacLdac && !ldacPrev) begin
                checkEq("frames per LDAC", frameQ.size(), 2);
                checkEq("frame A header", frameQ[0][15:12], {1'b0, DacCfgBits});
                checkEq("frame B header", frameQ[1][15:12], {1'b1, DacCfgBits});
                pairA = frameQ[0];
                pairB = frameQ[1];
                frameQ.delete();
                pairCount++;
            end
        end
        sclkPrev = dacSclk;
        csPrev   = dacCs;
        ldacPrev = dacLdac;
    end

    initial begin
        longint limitNs;
        limitNs = 0;
        wait (tableReady);
        for (int i = 0; i < NumRows; i++) begin
            limitNs += longint'(rows[i].count + 3) * SampleDiv * 4;
        end
        limitNs = 2 * limitNs;  // Margin for reset and the first transfer
        #(limitNs);
        $display("Timeout: the run did not finish within %0d ns", limitNs);
        $display(">>> FAIL");
        $fatal(1, "run timed out");
    end

    initial begin
        int nA;
        int nB;
        logic chgA;
        logic chgB;
        stimRow_t prev;
        seed    = 32'h6fdf;
        rst     = 1'b1;
        modeA   = modeDc;
        modeB   = modeDc;
        freqA   = '0;
        freqB   = '0;
        amplA   = '0;
        amplB   = '0;
        offsetA = '0;
        offsetB = '0;
        prev    = '{modeDc, modeDc, 0, 0, 0, 0, 0, 0, 0};  // Matches the idle inputs
        fillTable();
        tableReady = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        checkEq("dacCs", dacCs, 1);
        checkEq("dacLdac", dacLdac, 1);
        checkEq("dacSclk", dacSclk, 0);
        checkEq("dacSdi", dacSdi, 0);
        waitPair();
        checkEq("codeA", pairA[DacBits-1:0], DacMid);  // Reset codes go out first
        checkEq("codeB", pairB[DacBits-1:0], DacMid);
        nA = 0;
        nB = 0;
        for (int r = 0; r < NumRows; r++) begin
            @(negedge clk);  // Just after an LDAC pulse
            modeA   = rows[r].modeA;
            modeB   = rows[r].modeB;
            freqA   = freqHz_t'(rows[r].freqA);
            freqB   = freqHz_t'(rows[r].freqB);
            amplA   = ampl_t'(rows[r].amplA);
            amplB   = ampl_t'(rows[r].amplB);
            offsetA = ampl_t'(rows[r].offA);
            offsetB = ampl_t'(rows[r].offB);
            chgA = (rows[r].modeA != prev.modeA) || (rows[r].freqA != prev.freqA)
                   || (rows[r].amplA != prev.amplA) || (rows[r].offA != prev.offA);
            chgB = (rows[r].modeB != prev.modeB) || (rows[r].freqB != prev.freqB)
                   || (rows[r].amplB != prev.amplB) || (rows[r].offB != prev.offB);
            if (chgA) nA = -2;  // Third pair carries n=0
            if (chgB) nB = -2;
            for (int p = 0; p < rows[r].count + 2; p++) begin
                waitPair();
                if (p >= 2) begin
                    checkEq("codeA", pairA[DacBits-1:0], expCode(rows[r].modeA,
                            rows[r].freqA, rows[r].amplA, rows[r].offA, nA));
                    checkEq("codeB", pairB[DacBits-1:0], expCode(rows[r].modeB,
                            rows[r].freqB, rows[r].amplB, rows[r].offB, nB));
                end
                nA = nA + 1;
                if (nA >= periodOf(rows[r].freqA)) nA = 0;
                nB = nB + 1;
                if (nB >= periodOf(rows[r].freqB)) nB = 0;
            end
            prev = rows[r];
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* source/waveGenTop.sv */
`timescale 1ns/100ps
`default_nettype none

module waveGenTop import waveGenPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  waveMode_t modeA,
    input  waveMode_t modeB,
    input  freqHz_t   freqA,
    input  freqHz_t   freqB,
    input  ampl_t     amplA,
    input  ampl_t     amplB,
    input  ampl_t     offsetA,
    input  ampl_t     offsetB,
    output logic      dacCs,
    output logic      dacSclk,
    output logic      dacSdi,
    output logic      dacLdac
);

    logic     sampleTick;  // 50 kHz
    logic     bitTick;     // Half SPI bit
    dacCode_t codeA;
    dacCode_t codeB;

    tickDivider #(.Div(SampleDiv)) sampleDiv0 (.clk, .rst, .tick(sampleTick));
    tickDivider #(.Div(SpiHalfDiv)) spiDiv0 (.clk, .rst, .tick(bitTick));

    chanCfgIf cfgA ();
    chanCfgIf cfgB ();

    // Channel A
    stepCalc calcA (
        .clk, .rst, .sampleTick,
        .mode(modeA), .freq(freqA), .ampl(amplA), .offset(offsetA),
        .cfg(cfgA.src)
    );
    waveChannel chanA (.clk, .rst, .sampleTick, .cfg(cfgA.dst), .code(codeA));

    // Channel B
    stepCalc calcB (
        .clk, .rst, .sampleTick,
        .mode(modeB), .freq(freqB), .ampl(amplB), .offset(offsetB),
        .cfg(cfgB.src)
    );
    waveChannel chanB (.clk, .rst, .sampleTick, .cfg(cfgB.dst), .code(codeB));

    dacSpiWriter dacWriter0 (
        .clk, .rst, .sampleTick, .bitTick,
        .codeA, .codeB,
        .dacCs, .dacSclk, .dacSdi, .dacLdac
    );

endmodule

`default_nettype wire

/* source/dacSpiWriter.sv */
`timescale 1ns/100ps
`default_nettype none

module dacSpiWriter import waveGenPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     sampleTick,
    input  logic     bitTick,
    input  dacCode_t codeA,
    input  dacCode_t codeB,
    output logic     dacCs,
    output logic     dacSclk,
    output logic     dacSdi,
    output logic     dacLdac
);

    typedef enum logic [2:0] {
        sIdle,
        sFrameA,
        sGap,
        sFrameB,
        sLoad
    } wrState_t;

    wrState_t state;
    logic pending;                        // Codes latched, waiting for half-bit edge
    logic [$clog2(FrameBits)-1:0] bitCnt;
    logic [1:0] ldacCnt;
    logic [FrameBits-1:0] shiftReg;
    dacCode_t codeBHeld;
    logic inFrame;
    logic lastBit;

    assign inFrame = (state == sFrameA) || (state == sFrameB);
    assign lastBit = (bitCnt == $bits(bitCnt)'(FrameBits - 1));
    assign dacSdi  = inFrame && shiftReg[FrameBits-1];  // MSB first

    // Frame data, select bit then config then code
    always_ff @(posedge clk) begin
        if (state == sIdle && sampleTick) begin
            shiftReg  <= {1'b0, DacCfgBits, codeA};
            codeBHeld <= codeB;
        end else if (state == sGap && bitTick) begin
            shiftReg <= {1'b1, DacCfgBits, codeBHeld};
        end else if (inFrame && bitTick && dacSclk) begin
            shiftReg <= shiftReg << 1;  // Next bit while SCLK goes low
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= sIdle;
            pending <= 1'b0;
            bitCnt  <= '0;
            ldacCnt <= '0;
            dacCs   <= 1'b1;
            dacSclk <= 1'b0;
            dacLdac <= 1'b1;
        end else begin
            case (state)
                sIdle: begin
                    if (sampleTick) begin
                        pending <= 1'b1;
                    end else if (pending && bitTick) begin
                        pending <= 1'b0;
                        dacCs   <= 1'b0;
                        bitCnt  <= '0;
                        state   <= sFrameA;
                    end
                end
                sFrameA, sFrameB: begin
                    if (bitTick) begin
                        if (!dacSclk) begin
                            dacSclk <= 1'b1;  // DAC samples SDI here
                        end else begin
                            dacSclk <= 1'b0;
                            bitCnt  <= bitCnt + 1'b1;
                            if (lastBit) begin
                                dacCs <= 1'b1;
                                state <= (state == sFrameA) ? sGap : sLoad;
                            end
                        end
                    end
                end
                sGap: begin
                    // CS high for one half-bit between frames
                    if (bitTick) begin
                        dacCs  <= 1'b0;
                        bitCnt <= '0;
                        state  <= sFrameB;
                    end
                end
                sLoad: begin
                    if (bitTick) begin
                        ldacCnt <= ldacCnt + 1'b1;
                        if (ldacCnt == 2'd0) begin
                            dacLdac <= 1'b0;  // Update both outputs at once
                        end else if (ldacCnt == 2'd2) begin
                            dacLdac <= 1'b1;
                            ldacCnt <= '0;
                            state   <= sIdle;
                        end
                    end
                end
                default: state <= sIdle;
            endcase
        end
    end

    // Load only once both frames are complete
    assert property (@(posedge clk) disable iff (rst) !dacLdac |-> dacCs);

endmodule

`default_nettype wire

/* source/waveChannel.sv */
`timescale 1ns/100ps
`default_nettype none

module waveChannel import waveGenPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     sampleTick,
    chanCfgIf.dst    cfg,
    output dacCode_t code
);

    period_t n;        // Sample index within the period
    period_t idx;      // Index of the sample being registered
    period_t nInc;
    period_t half;
    period_t k;        // Ramp position
    logic signed [33:0] amplX;
    logic signed [33:0] prod;
    logic signed [33:0] wave;
    logic signed [33:0] sum;

    assign half = cfg.stepCount >> 1;
    assign nInc = n + 1'b1;

    // Restart wins over the wrap
    always_comb begin
        if (cfg.restart) begin
            idx = '0;
        end else if (nInc >= cfg.stepCount) begin
            idx = '0;
        end else begin
            idx = nInc;
        end
    end

    // Falling half of the triangle counts from its own start
    assign k = (cfg.mode == modeTri && idx >= half) ? idx - half : idx;

    assign amplX = 34'(cfg.ampl);
    assign prod  = 34'(cfg.stepVal) * $signed({18'd0, k});

    always_comb begin
        case (cfg.mode)
            modeSaw:    wave = prod - amplX;        // -ampl up to +ampl
            modeTri:    wave = (idx < half) ? prod - amplX : amplX - prod;
            modeSquare: wave = (idx < half) ? amplX : -amplX;  // Fixed 50 %
            default:    wave = '0;                  // DC, offset only
        endcase
    end

    assign sum = 34'(DacMid) + 34'(cfg.offset) + wave;

    always_ff @(posedge clk) begin
        if (rst) begin
            n    <= '0;
            code <= dacCode_t'(DacMid);
        end else if (sampleTick) begin
            n <= idx;
            // Clamp to the DAC range
            if (sum < 0) begin
                code <= '0;
            end else if (sum > 34'((1 << DacBits) - 1)) begin
                code <= '1;
            end else begin
                code <= sum[DacBits-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* source/stepCalc.sv */
`timescale 1ns/100ps
`default_nettype none

module stepCalc import waveGenPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      sampleTick,
    input  waveMode_t mode,
    input  freqHz_t   freq,
    input  ampl_t     ampl,
    input  ampl_t     offset,
    chanCfgIf.src     cfg
);

    freqHz_t freqEff;
    freqHz_t freqQ;             // Last captured frequency
    period_t quot;
    period_t periodNext;
    period_t halfNext;
    logic signed [17:0] twoAmpl;
    logic signed [17:0] sawStep;
    logic signed [17:0] triStep;
    logic first;                // No tick seen since reset
    logic changed;

    assign freqEff    = (freq == '0) ? freqHz_t'(1) : freq;  // 0 Hz runs as 1 Hz
    assign quot       = period_t'(SampleHz / freqEff);
    assign periodNext = (quot == '0) ? period_t'(1) : quot;  // Above SampleHz
    assign halfNext   = (periodNext < 2) ? period_t'(1) : periodNext >> 1;

    // Peak to peak span
    assign twoAmpl = {ampl[15], ampl, 1'b0};
    assign sawStep = twoAmpl / $signed({2'b00, periodNext});
    assign triStep = twoAmpl / $signed({2'b00, halfNext});   // Rises over half a period

    assign changed = (mode != cfg.mode) || (freq != freqQ)
                     || (ampl != cfg.ampl) || (offset != cfg.offset);

    always_ff @(posedge clk) begin
        if (rst) begin
            first         <= 1'b1;
            cfg.restart   <= 1'b0;
            cfg.mode      <= modeDc;
            cfg.stepCount <= period_t'(1);
            cfg.stepVal   <= '0;
            cfg.ampl      <= '0;
            cfg.offset    <= '0;
        end else if (sampleTick) begin
            first         <= 1'b0;
            cfg.restart   <= first || changed;  // Held until next tick
            cfg.mode      <= mode;
            cfg.stepCount <= periodNext;
            cfg.ampl      <= ampl;
            cfg.offset    <= offset;
            case (mode)
                modeSaw: cfg.stepVal <= sawStep[15:0];
                modeTri: cfg.stepVal <= triStep[15:0];
                default: cfg.stepVal <= '0;    // DC and square need no step
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sampleTick) freqQ <= freq;
    end

    // Channel index wraps at stepCount, zero would never wrap
    assert property (@(posedge clk) disable iff (rst)
        (cfg.mode != modeDc) |-> (cfg.stepCount != '0));

endmodule

`default_nettype wire

/* source/tickDivider.sv */
`timescale 1ns/100ps
`default_nettype none

module tickDivider #(
    parameter int Div = 2
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    logic [$clog2(Div)-1:0] cnt;
    logic wrap;

    assign wrap = (cnt == $bits(cnt)'(Div - 1));  // Last count of the period

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            cnt  <= wrap ? '0 : cnt + 1'b1;
            tick <= wrap;  // One cycle per Div clocks
        end
    end

    // Strobe must stay a single-cycle pulse
    assert property (@(posedge clk) disable iff (rst) tick |=> !tick);

endmodule

`default_nettype wire

/* source/chanCfgIf.sv */
`timescale 1ns/100ps
`default_nettype none

// One channel's captured settings, step calculator to channel generator
interface chanCfgIf import waveGenPkg::*; ();

    waveMode_t mode;
    period_t   stepCount;  // Samples per waveform period
    ampl_t     stepVal;    // Ramp increment per sample
    ampl_t     ampl;
    ampl_t     offset;
    logic      restart;    // Start again at n=0

    modport src (output mode, stepCount, stepVal, ampl, offset, restart);

    modport dst (input mode, stepCount, stepVal, ampl, offset, restart);

endinterface

`default_nettype wire

/* source/waveGenPkg.sv */
`default_nettype none

package waveGenPkg;

    // Clocking
    localparam int ClkHz      = 100_000_000;
    localparam int SampleHz   = 50_000;
    localparam int SampleDiv  = ClkHz / SampleHz;  // 2000 clocks per sample
    localparam int SpiHalfDiv = 25;                // Half bit, 2 MHz SCLK

    // DAC side
    localparam int DacBits   = 12;
    localparam int DacMid    = 2048;  // Zero volts
    localparam int FrameBits = 16;

    // Bits after channel select: BUF off, 1x gain, output active
    localparam logic [2:0] DacCfgBits = 3'b011;

    typedef enum logic [1:0] {
        modeDc     = 2'd0,
        modeSaw    = 2'd1,
        modeTri    = 2'd2,
        modeSquare = 2'd3
    } waveMode_t;

    typedef logic [15:0] freqHz_t;           // Hz
    typedef logic signed [15:0] ampl_t;      // In DAC codes
    typedef logic [DacBits-1:0] dacCode_t;
    typedef logic [15:0] period_t;           // Samples per period

endpackage

`default_nettype wire
